// ==== Bender.yml ====
package:
  name: crc_ahb

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/crc_pkg.sv
      - verilog/crc_ifs.sv
      - verilog/crc_byte_stage.sv
      - verilog/crc_input_feed.sv
      - verilog/crc_result_reg.sv
      - verilog/crc_host_interface.sv
      - verilog/crc_ahb_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/tb_crc_ahb.sv

// ==== dv/tb_crc_ahb.sv ====
////////////////////////////////////////
// CRC accelerator testbench
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none
`include "crc_cfg.svh"

module tb_crc_ahb;

	localparam int MAX_ENTRIES = 96;

	logic        HCLK;
	logic        HRESETn;
	logic [31:0] HADDR;
	logic [31:0] HWDATA;
	logic [2:0]  HSIZE;
	logic [1:0]  HTRANS;
	logic        HWRITE;
	logic        HSEL;
	logic        HREADY;
	wire  [31:0] HRDATA;
	wire         HREADYOUT;
	wire         HRESP;

	// Stimulus table
	string       t_name  [MAX_ENTRIES];
	logic        t_write [MAX_ENTRIES];
	logic [2:0]  t_ofs   [MAX_ENTRIES];
	logic [1:0]  t_size  [MAX_ENTRIES];
	logic [31:0] t_data  [MAX_ENTRIES];
	logic [31:0] t_exp   [MAX_ENTRIES];
	int          n_entries;

	// Reference register state
	logic [31:0] crc_m;
	logic [31:0] init_m;
	logic [31:0] poly_m;
	logic [7:0]  idr_m;
	// CR as read back with bit 0 never stored
	logic [31:0] cr_m;

	int          errors;
	int          checks;
	int          cycle_cnt;

	crc_ahb_top uut
	(
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.HADDR     (HADDR),
		.HWDATA    (HWDATA),
		.HSIZE     (HSIZE),
		.HTRANS    (HTRANS),
		.HWRITE    (HWRITE),
		.HSEL      (HSEL),
		.HREADY    (HREADY),
		.HRDATA    (HRDATA),
		.HREADYOUT (HREADYOUT),
		.HRESP     (HRESP)
	);

	always #5 HCLK = ~HCLK;

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	// Reverse the low n bits and clear the rest
	function automatic logic [31:0] reflect(input logic [31:0] v, input int n);
		logic [31:0] r;
		int          k;
		r = 32'h0;
		for (k = 0; k < n; k++)
			r[k] = v[n - 1 - k];
		return r;
	endfunction

	function automatic logic [31:0] reverse_in(input logic [31:0] v, input logic [1:0] mode);
		logic [31:0] r;
		logic [31:0] tmp;
		int          k;
		r = v;
		if (mode == 2'b01)
		begin
			for (k = 0; k < 4; k++)
			begin
				tmp = reflect(v >> (8 * k), 8);
				r[8 * k +: 8] = tmp[7:0];
			end
		end
		else if (mode == 2'b10)
		begin
			for (k = 0; k < 2; k++)
			begin
				tmp = reflect(v >> (16 * k), 16);
				r[16 * k +: 16] = tmp[15:0];
			end
		end
		else if (mode == 2'b11)
			r = reflect(v, 32);
		return r;
	endfunction

	// CR bits 4:3 select the width
	function automatic int width_bits(input logic [31:0] cr);
		case (cr[4:3])
			2'b00:   return 32;
			2'b01:   return 16;
			default: return 8;
		endcase
	endfunction

	function automatic logic [31:0] low_mask(input int w);
		if (w == 32)
			return 32'hFFFFFFFF;
		return (32'h1 << w) - 32'h1;
	endfunction

	// Byte xored into the top of the register and shifted eight times
	function automatic logic [31:0] fold_byte(input logic [31:0] crc, input logic [7:0] data,
	                                          input int w, input logic [31:0] poly);
		logic [31:0] mask;
		logic [31:0] c;
		int          k;
		mask = low_mask(w);
		c    = (crc & mask) ^ ({24'h0, data} << (w - 8));
		for (k = 0; k < 8; k++)
		begin
			if (c[w - 1])
				c = ((c << 1) ^ poly) & mask;
			else
				c = (c << 1) & mask;
		end
		return c;
	endfunction

	// Register write as the model sees it
	task automatic apply_write(input logic [2:0] ofs, input logic [1:0] size,
	                           input logic [31:0] data);
		logic [31:0] x;
		int          nb;
		int          k;
		begin
			case (ofs)
				`CRC_DR_OFS:
				begin
					nb = (size == 2'd0) ? 1 : ((size == 2'd1) ? 2 : 4);
					x  = reverse_in(data, cr_m[6:5]);
					// Most significant valid byte first
					for (k = nb - 1; k >= 0; k--)
						crc_m = fold_byte(crc_m, x[8 * k +: 8], width_bits(cr_m), poly_m);
				end
				`CRC_IDR_OFS:  idr_m  = data[7:0];
				`CRC_INIT_OFS: init_m = data;
				`CRC_POL_OFS:  poly_m = data;
				`CRC_CR_OFS:
				begin
					cr_m = data & 32'h000000F8;
					if (data[0])
						crc_m = init_m;
				end
				default: ;
			endcase
		end
	endtask

	function automatic logic [31:0] expected_read(input logic [2:0] ofs);
		int w;
		w = width_bits(cr_m);
		case (ofs)
			`CRC_DR_OFS:   return cr_m[7] ? reflect(crc_m, w) : (crc_m & low_mask(w));
			`CRC_IDR_OFS:  return {24'h0, idr_m};
			`CRC_CR_OFS:   return cr_m;
			`CRC_INIT_OFS: return init_m;
			`CRC_POL_OFS:  return poly_m;
			default:       return 32'h0;
		endcase
	endfunction

	////////////////////////////////////////
	// Table building
	////////////////////////////////////////

	task automatic add_entry(input string name, input logic wr, input logic [2:0] ofs,
	                         input logic [1:0] size, input logic [31:0] data,
	                         input logic [31:0] exp);
		begin
			t_name[n_entries]  = name;
			t_write[n_entries] = wr;
			t_ofs[n_entries]   = ofs;
			t_size[n_entries]  = size;
			t_data[n_entries]  = data;
			t_exp[n_entries]   = exp;
			n_entries++;
		end
	endtask

	task automatic write_entry(input string name, input logic [2:0] ofs,
	                           input logic [1:0] size, input logic [31:0] data);
		begin
			add_entry(name, 1'b1, ofs, size, data, 32'h0);
			apply_write(ofs, size, data);
		end
	endtask

	task automatic read_entry(input string name, input logic [2:0] ofs);
		begin
			add_entry(name, 1'b0, ofs, 2'd2, 32'h0, expected_read(ofs));
		end
	endtask

	// Fixed expectation straight from the register description
	task automatic read_value(input string name, input logic [2:0] ofs, input logic [31:0] exp);
		begin
			add_entry(name, 1'b0, ofs, 2'd2, 32'h0, exp);
		end
	endtask

	task automatic build_table;
		int k;
		int m;
		begin
			// Reset values with the CRC starting at init
			read_value("reset_init", `CRC_INIT_OFS, 32'hFFFFFFFF);
			read_value("reset_pol", `CRC_POL_OFS, 32'h04C11DB7);
			read_value("reset_crc", `CRC_DR_OFS, 32'hFFFFFFFF);
			read_value("reset_cr", `CRC_CR_OFS, 32'h0);

			// Back to back words at 32 bits
			for (k = 0; k < 4; k++)
				write_entry($sformatf("w32_word%0d", k), `CRC_DR_OFS, 2'd2, $urandom());
			read_entry("w32_crc", `CRC_DR_OFS);

			// 16-bit with new polynomial and init
			write_entry("w16_pol", `CRC_POL_OFS, 2'd2, 32'h00001021);
			write_entry("w16_init", `CRC_INIT_OFS, 2'd2, 32'h0000FFFF);
			write_entry("w16_cr", `CRC_CR_OFS, 2'd2, 32'h00000009);
			read_entry("w16_cr_rd", `CRC_CR_OFS);
			for (k = 0; k < 3; k++)
				write_entry($sformatf("w16_half%0d", k), `CRC_DR_OFS, 2'd1, $urandom());
			for (k = 0; k < 2; k++)
				write_entry($sformatf("w16_byte%0d", k), `CRC_DR_OFS, 2'd0, $urandom());
			read_entry("w16_crc", `CRC_DR_OFS);

			// 8-bit
			write_entry("w8_pol", `CRC_POL_OFS, 2'd2, 32'h00000007);
			write_entry("w8_cr", `CRC_CR_OFS, 2'd2, 32'h00000011);
			for (k = 0; k < 3; k++)
				write_entry($sformatf("w8_byte%0d", k), `CRC_DR_OFS, 2'd0, $urandom());
			write_entry("w8_half", `CRC_DR_OFS, 2'd1, $urandom());
			write_entry("w8_word", `CRC_DR_OFS, 2'd2, $urandom());
			read_entry("w8_crc", `CRC_DR_OFS);

			// Input reversal modes at 32 bits
			write_entry("rev_pol", `CRC_POL_OFS, 2'd2, 32'h04C11DB7);
			write_entry("rev_init", `CRC_INIT_OFS, 2'd2, 32'hFFFFFFFF);
			for (m = 0; m < 4; m++)
			begin
				write_entry($sformatf("rev%0d_cr", m), `CRC_CR_OFS, 2'd2, (m << 5) | 1);
				write_entry($sformatf("rev%0d_word0", m), `CRC_DR_OFS, 2'd2, $urandom());
				write_entry($sformatf("rev%0d_word1", m), `CRC_DR_OFS, 2'd2, $urandom());
				write_entry($sformatf("rev%0d_byte", m), `CRC_DR_OFS, 2'd0, $urandom());
				read_entry($sformatf("rev%0d_crc", m), `CRC_DR_OFS);
			end

			// Output reversal at 32 and 16 bits
			write_entry("out32_cr", `CRC_CR_OFS, 2'd2, 32'h00000081);
			write_entry("out32_word0", `CRC_DR_OFS, 2'd2, $urandom());
			write_entry("out32_word1", `CRC_DR_OFS, 2'd2, $urandom());
			read_entry("out32_crc", `CRC_DR_OFS);
			write_entry("out16_cr", `CRC_CR_OFS, 2'd2, 32'h00000089);
			write_entry("out16_half0", `CRC_DR_OFS, 2'd1, $urandom());
			write_entry("out16_half1", `CRC_DR_OFS, 2'd1, $urandom());
			// New init right behind a DR write stalls once and leaves the CRC alone
			write_entry("restart_init", `CRC_INIT_OFS, 2'd2, 32'h5A5A5A5A);
			read_entry("out16_crc", `CRC_DR_OFS);

			// Restart from the new init and check the scratch byte
			write_entry("restart_cr", `CRC_CR_OFS, 2'd2, 32'h00000001);
			read_value("restart_crc", `CRC_DR_OFS, 32'h5A5A5A5A);
			write_entry("restart_word", `CRC_DR_OFS, 2'd2, $urandom());
			read_entry("restart_fold", `CRC_DR_OFS);
			write_entry("idr_wr", `CRC_IDR_OFS, 2'd2, 32'hABCDEF3C);
			read_value("idr_rd", `CRC_IDR_OFS, 32'h0000003C);
		end
	endtask

	////////////////////////////////////////
	// AHB master
	////////////////////////////////////////

	// Address phase of entry idx or IDLE past the end
	task automatic drive_address(input int idx);
		begin
			if (idx < n_entries)
			begin
				HSEL   <= 1'b1;
				HTRANS <= 2'b10;
				HADDR  <= {27'h0, t_ofs[idx], 2'b00};
				HWRITE <= t_write[idx];
				HSIZE  <= {1'b0, t_size[idx]};
			end
			else
			begin
				HSEL   <= 1'b0;
				HTRANS <= 2'b00;
				HWRITE <= 1'b0;
			end
		end
	endtask

	// Returns at the falling edge before the completing rising edge
	task automatic wait_ready(output int waits);
		begin
			waits = 0;
			@(negedge HCLK);
			while (!HREADYOUT)
			begin
				waits++;
				@(negedge HCLK);
			end
		end
	endtask

	task automatic run_table;
		int          i;
		int          waits;
		int          exp_waits;
		logic        prev_dr_write;
		logic        cur_dr;
		logic        cur_init_wr;
		begin
			prev_dr_write = 1'b0;
			@(posedge HCLK);
			drive_address(0);
			for (i = 0; i < n_entries; i++)
			begin
				// Address of entry i taken and its data phase starting
				@(posedge HCLK);
				HWDATA <= t_data[i];
				drive_address(i + 1);
				wait_ready(waits);

				// One wait state on DR or INIT right behind a DR write
				cur_dr      = (t_ofs[i] == `CRC_DR_OFS);
				cur_init_wr = (t_ofs[i] == `CRC_INIT_OFS) && t_write[i];
				exp_waits   = (prev_dr_write && (cur_dr || cur_init_wr)) ? 1 : 0;
				checks++;
				if (waits != exp_waits)
				begin
					$display("CHECK FAILED %s wait states: expected %0d, actual %0d",
					         t_name[i], exp_waits, waits);
					errors++;
				end
				checks++;
				if (HRESP !== 1'b0)
				begin
					$display("CHECK FAILED %s HRESP: expected 0, actual %b", t_name[i], HRESP);
					errors++;
				end
				if (!t_write[i])
				begin
					checks++;
					if (HRDATA !== t_exp[i])
					begin
						$display("CHECK FAILED %s: expected %h, actual %h",
						         t_name[i], t_exp[i], HRDATA);
						errors++;
					end
				end
				prev_dr_write = cur_dr && t_write[i];
			end
			@(posedge HCLK);
			HWDATA <= 32'h0;
		end
	endtask

	////////////////////////////////////////
	// Run control
	////////////////////////////////////////

	// Cycle limit from the table length
	initial
	begin : watchdog
		#1;
		while (cycle_cnt < n_entries * 8)
		begin
			@(posedge HCLK);
			cycle_cnt++;
		end
		$display("Timeout: run did not complete within %0d cycles", n_entries * 8);
		$display("sim failed");
		$finish;
	end

	initial
	begin
		HCLK      = 1'b0;
		HRESETn   = 1'b0;
		HADDR     = 32'h0;
		HWDATA    = 32'h0;
		HSIZE     = 3'b010;
		HTRANS    = 2'b00;
		HWRITE    = 1'b0;
		HSEL      = 1'b0;
		// Only slave on the bus
		HREADY    = 1'b1;
		errors    = 0;
		checks    = 0;
		cycle_cnt = 0;
		n_entries = 0;

		void'($urandom(32'hf6cf21c8));
		crc_m    = `CRC_INIT_RST;
		init_m   = `CRC_INIT_RST;
		poly_m   = `CRC_POLY_RST;
		idr_m    = 8'h00;
		cr_m     = 32'h0;
		build_table();

		repeat (2) @(posedge HCLK);
		HRESETn <= 1'b1;

		@(negedge HCLK);
		checks++;
		if (HREADYOUT !== 1'b1)
		begin
			$display("CHECK FAILED reset_ready: expected 1, actual %b", HREADYOUT);
			errors++;
		end

		run_table();

		$display("%0d errors in %0d checks over %0d entries", errors, checks, n_entries);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== include/crc_cfg.svh ====
////////////////////////////////////////
// CRC accelerator configuration
////////////////////////////////////////

`ifndef CRC_CFG_SVH
`define CRC_CFG_SVH

// Register word offsets, taken from HADDR[4:2]
// Data register, write feeds the chain and read returns the CRC
`define CRC_DR_OFS   3'h0
// Scratch ID byte
`define CRC_IDR_OFS  3'h1
// Control word
`define CRC_CR_OFS   3'h2
// Init value and polynomial
`define CRC_INIT_OFS 3'h4
`define CRC_POL_OFS  3'h5

// Reset values of init and polynomial
// Polynomial defaults to CRC-32 (IEEE 802.3)
`define CRC_INIT_RST 32'hFFFFFFFF
`define CRC_POLY_RST 32'h04C11DB7

// Number of byte stages in the fold chain
// One lane per byte of a 32-bit data word
`define CRC_LANES 4

`endif

// ==== tb.f ====
+incdir+include
verilog/crc_pkg.sv
verilog/crc_ifs.sv
verilog/crc_byte_stage.sv
verilog/crc_input_feed.sv
verilog/crc_result_reg.sv
verilog/crc_host_interface.sv
verilog/crc_ahb_top.sv
dv/tb_crc_ahb.sv

// ==== verilog/crc_ahb_top.sv ====
////////////////////////////////////////
// CRC accelerator, AHB-Lite top
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none
`include "crc_cfg.svh"

module crc_ahb_top
(
	input  wire         HCLK,
	input  wire         HRESETn,
	input  wire  [31:0] HADDR,
	input  wire  [31:0] HWDATA,
	input  wire  [2:0]  HSIZE,
	input  wire  [1:0]  HTRANS,
	input  wire         HWRITE,
	input  wire         HSEL,
	input  wire         HREADY,
	output logic [31:0] HRDATA,
	output logic        HREADYOUT,
	output logic        HRESP
);

	crc_feed_if feed_if();
	crc_ctrl_if ctrl_if();

	// Lanes from the feed into the stage chain
	logic [`CRC_LANES-1:0][7:0] lane_byte;
	logic [`CRC_LANES-1:0]      lane_en;
	logic                       step;

	// CRC between stages
	// Entry 0 is the stored CRC, the last entry goes back to the register
	logic [31:0]                chain [0:`CRC_LANES];
	logic [31:0]                poly;
	crc_pkg::crc_width_e        width;

	crc_host_interface u_host
	(
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.HADDR     (HADDR),
		.HWDATA    (HWDATA),
		.HSIZE     (HSIZE),
		.HTRANS    (HTRANS),
		.HWRITE    (HWRITE),
		.HSEL      (HSEL),
		.HREADY    (HREADY),
		.HRDATA    (HRDATA),
		.HREADYOUT (HREADYOUT),
		.HRESP     (HRESP),
		.feed      (feed_if.host),
		.ctrl      (ctrl_if.host)
	);

	crc_input_feed u_feed
	(
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.feed      (feed_if.feed),
		.lane_byte (lane_byte),
		.lane_en   (lane_en),
		.step      (step)
	);

	// One stage per byte lane
	for (genvar i = 0; i < `CRC_LANES; i++)
	begin : g_lane
		crc_byte_stage u_stage
		(
			.crc_in    (chain[i]),
			.lane_byte (lane_byte[i]),
			.lane_en   (lane_en[i]),
			.poly      (poly),
			.width     (width),
			.crc_out   (chain[i+1])
		);
	end

	crc_result_reg u_result
	(
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.step      (step),
		.chain_crc (chain[`CRC_LANES]),
		.full      (feed_if.full),
		.ctrl      (ctrl_if.result),
		.crc_cur   (chain[0]),
		.poly      (poly),
		.width     (width)
	);

endmodule

`default_nettype wire

// ==== verilog/crc_byte_stage.sv ====
////////////////////////////////////////
// CRC byte fold stage
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module crc_byte_stage
(
	input  wire                      [31:0] crc_in,
	input  wire                      [7:0]  lane_byte,
	input  wire                             lane_en,
	input  wire                      [31:0] poly,
	input  wire crc_pkg::crc_width_e        width,
	output logic                     [31:0] crc_out
);

	always_comb
	begin : fold
		logic [31:0] mask;
		logic [31:0] crc;
		logic        fb;
		int          msb;

		// Active CRC bits, reserved width code acts as 8-bit
		case (width)
			crc_pkg::CRC_W32:
			begin
				mask = 32'hFFFFFFFF;
				msb  = 31;
			end
			crc_pkg::CRC_W16:
			begin
				mask = 32'h0000FFFF;
				msb  = 15;
			end
			default:
			begin
				mask = 32'h000000FF;
				msb  = 7;
			end
		endcase

		crc = crc_in & mask;
		// MSB-first, non-reflected
		for (int b = 7; b >= 0; b--)
		begin
			fb  = crc[msb] ^ lane_byte[b];
			// Shift out of the top bit, upper bits stay zero
			crc = (crc << 1) & mask;
			if (fb)
				crc = crc ^ (poly & mask);
		end

		// Idle lane leaves the CRC as it is
		crc_out = lane_en ? crc : crc_in;
	end

endmodule

`default_nettype wire

// ==== verilog/crc_host_interface.sv ====
////////////////////////////////////////
// CRC AHB-Lite slave interface
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none
`include "crc_cfg.svh"

module crc_host_interface
(
	input  wire         HCLK,
	input  wire         HRESETn,
	input  wire  [31:0] HADDR,
	input  wire  [31:0] HWDATA,
	input  wire  [2:0]  HSIZE,
	input  wire  [1:0]  HTRANS,
	input  wire         HWRITE,
	input  wire         HSEL,
	input  wire         HREADY,
	output logic [31:0] HRDATA,
	output logic        HREADYOUT,
	output logic        HRESP,
	crc_feed_if.host    feed,
	crc_ctrl_if.host    ctrl
);

	// Address phase captured for the data phase
	logic [2:0]         haddr_pp;
	crc_pkg::bus_size_e hsize_pp;
	logic               hwrite_pp;
	// Selected and NONSEQ or SEQ
	logic               active_pp;

	// Control word
	// [4] output reversal, [3:2] input reversal, [1:0] width
	logic [4:0]         cr_q;

	logic               sample_bus;
	logic               write_en;
	logic               dr_sel;
	logic               idr_sel;
	logic               cr_sel;
	logic               init_sel;
	logic               pol_sel;
	logic               cr_en;
	logic               dr_wait;
	logic               init_wait;

	////////////////////////////////////////
	// Address phase pipeline
	////////////////////////////////////////

	// Bus sampled only when the previous transfer completes
	assign sample_bus = HREADY && HREADYOUT;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			haddr_pp  <= 3'h0;
			hsize_pp  <= crc_pkg::SIZE_WORD;
			hwrite_pp <= 1'b0;
			active_pp <= 1'b0;
		end
		else if (sample_bus)
		begin
			// Word registers, so only bits 4 to 2 decode
			haddr_pp  <= HADDR[4:2];
			hsize_pp  <= crc_pkg::bus_size_e'(HSIZE[1:0]);
			hwrite_pp <= HWRITE;
			// HTRANS[1] marks NONSEQ and SEQ
			active_pp <= HSEL && HTRANS[1];
		end
	end

	////////////////////////////////////////
	// Register decode
	////////////////////////////////////////

	assign dr_sel   = (haddr_pp == `CRC_DR_OFS);
	assign idr_sel  = (haddr_pp == `CRC_IDR_OFS);
	assign cr_sel   = (haddr_pp == `CRC_CR_OFS);
	assign init_sel = (haddr_pp == `CRC_INIT_OFS);
	assign pol_sel  = (haddr_pp == `CRC_POL_OFS);

	assign write_en = active_pp && hwrite_pp;
	assign cr_en    = cr_sel && write_en;

	// DR access of either kind stalls while a word is still folding
	assign dr_wait   = dr_sel && active_pp && feed.full;
	// Init must not change under a pending chain reload
	assign init_wait = init_sel && write_en && ctrl.reset_pending;

	assign HREADYOUT = !(dr_wait || init_wait);
	// No error responses
	assign HRESP     = 1'b0;

	// Feed side
	// HWDATA arrives in the data phase, no extra register
	assign feed.wdata.word = HWDATA;
	assign feed.size       = hsize_pp;
	assign feed.rev_in     = crc_pkg::rev_in_e'(cr_q[3:2]);
	assign feed.push       = dr_sel && write_en && !feed.full;

	// Result block side
	assign ctrl.wdata       = HWDATA;
	assign ctrl.init_en     = init_sel && write_en && !ctrl.reset_pending;
	assign ctrl.poly_en     = pol_sel && write_en;
	assign ctrl.idr_en      = idr_sel && write_en;
	assign ctrl.reset_chain = cr_en && HWDATA[0];
	assign ctrl.width       = crc_pkg::crc_width_e'(cr_q[1:0]);
	assign ctrl.rev_out     = cr_q[4];

	////////////////////////////////////////
	// Control word and read mux
	////////////////////////////////////////

	// Bit 0 is a self-clearing command, not stored
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			cr_q <= 5'h00;
		else if (cr_en)
			cr_q <= HWDATA[7:3];
	end

	always_comb
	begin
		case (haddr_pp)
			`CRC_DR_OFS:   HRDATA = ctrl.crc_out;
			`CRC_IDR_OFS:  HRDATA = {24'h0, ctrl.idr_out};
			// Control read back in its write position, bit 0 reads zero
			`CRC_CR_OFS:   HRDATA = {24'h0, cr_q, 3'h0};
			`CRC_INIT_OFS: HRDATA = ctrl.init_out;
			`CRC_POL_OFS:  HRDATA = ctrl.poly_out;
			default:       HRDATA = 32'h0;
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/crc_ifs.sv ====
////////////////////////////////////////
// CRC internal interfaces
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

// Host to input feed, one data word per push
interface crc_feed_if;

	// Raw bus word, not yet reversed
	crc_pkg::crc_word_u wdata;
	crc_pkg::bus_size_e size;
	crc_pkg::rev_in_e   rev_in;
	// One-cycle strobe in the DR write data phase
	logic               push;
	// Word held and still folding
	logic               full;

	modport host (output wdata, output size, output rev_in, output push, input full);
	modport feed (input wdata, input size, input rev_in, input push, output full);

endinterface

// Host to result block, register writes and read values
interface crc_ctrl_if;

	logic [31:0]         wdata;
	// Write strobes, one cycle each
	logic                init_en;
	logic                poly_en;
	logic                idr_en;
	// CRC reload from init
	logic                reset_chain;
	crc_pkg::crc_width_e width;
	logic                rev_out;
	// Read back values
	logic [31:0]         crc_out;
	logic [31:0]         init_out;
	logic [31:0]         poly_out;
	logic [7:0]          idr_out;
	// Init write has to wait
	logic                reset_pending;

	modport host
	(
		output wdata, output init_en, output poly_en, output idr_en,
		output reset_chain, output width, output rev_out,
		input crc_out, input init_out, input poly_out, input idr_out,
		input reset_pending
	);

	modport result
	(
		input wdata, input init_en, input poly_en, input idr_en,
		input reset_chain, input width, input rev_out,
		output crc_out, output init_out, output poly_out, output idr_out,
		output reset_pending
	);

endinterface

`default_nettype wire

// ==== verilog/crc_input_feed.sv ====
////////////////////////////////////////
// CRC input word buffer
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none
`include "crc_cfg.svh"

module crc_input_feed
(
	input  wire                          HCLK,
	input  wire                          HRESETn,
	crc_feed_if.feed                     feed,
	output logic [`CRC_LANES-1:0][7:0]   lane_byte,
	output logic [`CRC_LANES-1:0]        lane_en,
	output logic                         step
);

	// Buffered word, already bit reversed
	crc_pkg::crc_word_u buf_q;
	crc_pkg::bus_size_e size_q;
	logic               full_q;
	// Valid bytes in the buffered word
	logic [2:0]         nbytes;

	// Bit reversal within bytes, halfwords or the whole word
	function automatic logic [31:0] rev_word(input logic [31:0] w, input crc_pkg::rev_in_e mode);
		logic [31:0] r;
		r = w;
		case (mode)
			crc_pkg::REV_BYTE:
			begin
				for (int i = 0; i < 32; i++)
					r[i] = w[(i / 8) * 8 + 7 - (i % 8)];
			end
			crc_pkg::REV_HALF:
			begin
				for (int i = 0; i < 32; i++)
					r[i] = w[(i / 16) * 16 + 15 - (i % 16)];
			end
			crc_pkg::REV_WORD:
			begin
				for (int i = 0; i < 32; i++)
					r[i] = w[31 - i];
			end
			default:
				r = w;
		endcase
		return r;
	endfunction

	// Payload, loaded on push only
	always_ff @(posedge HCLK)
	begin
		if (feed.push)
		begin
			buf_q.word <= rev_word(feed.wdata.word, feed.rev_in);
			size_q     <= feed.size;
		end
	end

	// Whole word folds in one cycle, so the buffer drains right after it fills
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			full_q <= 1'b0;
		else
			full_q <= feed.push;
	end

	assign feed.full = full_q;
	// Result register loads the chain while the word is held
	assign step      = full_q;

	// Reserved size code behaves as a word
	always_comb
	begin
		case (size_q)
			crc_pkg::SIZE_BYTE: nbytes = 3'd1;
			crc_pkg::SIZE_HALF: nbytes = 3'd2;
			default:            nbytes = 3'd4;
		endcase
	end

	// Most significant valid byte to lane 0
	always_comb
	begin
		for (int i = 0; i < `CRC_LANES; i++)
		begin
			if (i < nbytes)
			begin
				lane_en[i]   = 1'b1;
				lane_byte[i] = buf_q.bytes[nbytes - 1 - i];
			end
			else
			begin
				lane_en[i]   = 1'b0;
				lane_byte[i] = 8'h00;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/crc_pkg.sv ====
////////////////////////////////////////
// CRC accelerator types
////////////////////////////////////////

`default_nettype none

package crc_pkg;

	// One data word, seen as a plain word or as four bytes
	typedef union packed
	{
		logic [31:0]      word;
		logic [3:0][7:0]  bytes;
	} crc_word_u;

	// CRC width select, 11 behaves as 8-bit
	typedef enum logic [1:0]
	{
		CRC_W32  = 2'b00,
		CRC_W16  = 2'b01,
		CRC_W8   = 2'b10,
		CRC_W8_R = 2'b11
	} crc_width_e;

	// Input bit reversal granularity
	typedef enum logic [1:0]
	{
		REV_NONE = 2'b00,
		REV_BYTE = 2'b01,
		REV_HALF = 2'b10,
		REV_WORD = 2'b11
	} rev_in_e;

	// Data word size, same codes as HSIZE
	typedef enum logic [1:0]
	{
		SIZE_BYTE = 2'd0,
		SIZE_HALF = 2'd1,
		SIZE_WORD = 2'd2
	} bus_size_e;

endpackage

`default_nettype wire

// ==== verilog/crc_result_reg.sv ====
////////////////////////////////////////
// CRC result and setup registers
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none
`include "crc_cfg.svh"

module crc_result_reg
(
	input  wire                        HCLK,
	input  wire                        HRESETn,
	input  wire                        step,
	input  wire                 [31:0] chain_crc,
	input  wire                        full,
	crc_ctrl_if.result                 ctrl,
	output logic                [31:0] crc_cur,
	output logic                [31:0] poly,
	output crc_pkg::crc_width_e        width
);

	logic [31:0] crc_q;
	logic [31:0] init_q;
	logic [31:0] poly_q;
	logic [7:0]  idr_q;
	// Valid bits of the CRC at the selected width
	logic [31:0] width_mask;

	// Reverse the low bits of the selected width, rest zero
	function automatic logic [31:0] rev_low(input logic [31:0] v, input crc_pkg::crc_width_e w);
		logic [31:0] r;
		for (int i = 0; i < 32; i++)
			r[i] = v[31 - i];
		case (w)
			crc_pkg::CRC_W32: return r;
			crc_pkg::CRC_W16: return {16'h0, r[31:16]};
			default:          return {24'h0, r[31:24]};
		endcase
	endfunction

	////////////////////////////////////////
	// Registers
	////////////////////////////////////////

	// Reload from init wins over a fold in the same cycle
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			crc_q <= `CRC_INIT_RST;
		else if (ctrl.reset_chain)
			crc_q <= init_q;
		else if (step)
			crc_q <= chain_crc;
	end

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			init_q <= `CRC_INIT_RST;
			poly_q <= `CRC_POLY_RST;
			idr_q  <= 8'h00;
		end
		else
		begin
			if (ctrl.init_en)
				init_q <= ctrl.wdata;
			if (ctrl.poly_en)
				poly_q <= ctrl.wdata;
			// Scratch byte, upper bits of the write ignored
			if (ctrl.idr_en)
				idr_q <= ctrl.wdata[7:0];
		end
	end

	////////////////////////////////////////
	// Read path and chain outputs
	////////////////////////////////////////

	always_comb
	begin
		case (ctrl.width)
			crc_pkg::CRC_W32: width_mask = 32'hFFFFFFFF;
			crc_pkg::CRC_W16: width_mask = 32'h0000FFFF;
			default:          width_mask = 32'h000000FF;
		endcase
	end

	// Output reversal only on the read path, the chain sees the raw CRC
	assign ctrl.crc_out = ctrl.rev_out ? rev_low(crc_q, ctrl.width) : (crc_q & width_mask);

	assign ctrl.init_out      = init_q;
	assign ctrl.poly_out      = poly_q;
	assign ctrl.idr_out       = idr_q;
	// A word in flight still has to land in the CRC
	assign ctrl.reset_pending = full;

	assign crc_cur = crc_q;
	assign poly    = poly_q;
	assign width   = ctrl.width;

endmodule

`default_nettype wire
